// File: common/siggen_defines.svh
/*
 * Widths, CORDIC depth and settings-bus register map for the signal generator
 */
`ifndef SIGGEN_DEFINES_SVH
`define SIGGEN_DEFINES_SVH

// Settings bus
`define SIGGEN_ADDR_W 8
`define SIGGEN_DATA_W 32

// Sample path
`define SIGGEN_SAMPLE_W 16
`define SIGGEN_PHASE_W 24

// Micro-rotations after the quadrant step
`define SIGGEN_CORDIC_STAGES 14

// User registers, above the shell register space
`define SIGGEN_SR_FREQ 8'd128
`define SIGGEN_SR_CARTESIAN 8'd130
`define SIGGEN_SR_ENABLE 8'd132
`define SIGGEN_SR_AMPLITUDE 8'd138
`define SIGGEN_SR_PKT_SIZE 8'd140

`endif

// File: common/siggen_pkg.sv
/*
 * Signal generator types: register set, output sample and packet header
 */
`include "siggen_defines.svh"

package siggen_pkg;

  // Generator register set
  typedef struct packed {
    logic [`SIGGEN_PHASE_W-1:0]  freq_step;
    logic [`SIGGEN_SAMPLE_W-1:0] start_i;
    logic [`SIGGEN_SAMPLE_W-1:0] start_q;
    logic [15:0]                 amplitude;  // unsigned Q1.15
    logic [15:0]                 pkt_size;
    logic                        enable;
  } siggen_cfg_t;

  // One stream word, I in the upper half
  typedef struct packed {
    logic signed [`SIGGEN_SAMPLE_W-1:0] i;
    logic signed [`SIGGEN_SAMPLE_W-1:0] q;
  } siggen_sample_t;

  // CVITA-style packet header
  typedef struct packed {
    logic [1:0]  pkt_type;
    logic        eob;
    logic        has_time;
    logic [11:0] seqnum;
    logic [15:0] length;     // bytes
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } cvita_hdr_t;

endpackage

// File: hw/siggen_packet_framer.sv
/*
 * Packet framer: sample counter, last marker and CVITA-style header
 */
`timescale 1ns/10ps

module siggen_packet_framer (
  input  logic                       ce_clk,
  input  logic                       i_rst,
  input  siggen_pkg::siggen_cfg_t    i_cfg,
  input  logic [15:0]                i_src_sid,
  input  logic [15:0]                i_dst_sid,
  input  siggen_pkg::siggen_sample_t i_sample,
  input  logic                       i_valid,
  output logic                       o_ready,
  output logic [31:0]                o_tdata,
  output logic                       o_tvalid,
  output logic                       o_tlast,
  input  logic                       i_tready,
  output siggen_pkg::cvita_hdr_t     o_hdr
);

  logic [15:0] count_q;
  logic [11:0] seqnum_q;
  logic        at_end;
  logic        xfer;

  // Stream passes through with no added latency
  assign o_tdata  = i_sample;
  assign o_tvalid = i_valid;
  assign o_ready  = i_tready;

  // Also catches a count left above a size that was lowered mid-packet
  assign at_end  = (count_q >= (i_cfg.pkt_size - 16'd1));
  assign o_tlast = i_valid && at_end;
  assign xfer    = i_valid && i_tready;

  ////////////////////////////////////////////////////////////////////////////
  // Sample and packet counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      count_q  <= '0;
      seqnum_q <= '0;
    end else if (xfer) begin
      if (at_end) begin
        count_q  <= '0;
        // 12-bit field, wraps at 4096
        seqnum_q <= seqnum_q + 12'd1;
      end else begin
        count_q <= count_q + 16'd1;
      end
    end
  end

  always_comb begin
    o_hdr.pkt_type = 2'b00;
    o_hdr.eob      = 1'b0;
    o_hdr.has_time = 1'b0;
    o_hdr.seqnum   = seqnum_q;
    // Four bytes per I/Q word
    o_hdr.length   = {i_cfg.pkt_size[13:0], 2'b00};
    o_hdr.src_sid  = i_src_sid;
    o_hdr.dst_sid  = i_dst_sid;
  end

  // A stalled last beat stays presented as a valid last beat
  a_last_held: assert property (
    @(posedge ce_clk) disable iff (i_rst) (o_tlast && !i_tready) |=> (o_tvalid && o_tlast));

endmodule

// File: hw/siggen_settings_decode.sv
/*
 * Settings-bus register decoder for the signal generator
 */
`timescale 1ns/10ps
`include "siggen_defines.svh"

module siggen_settings_decode (
  input  logic                      ce_clk,
  input  logic                      i_rst,
  input  logic                      i_set_stb,
  input  logic [`SIGGEN_ADDR_W-1:0] i_set_addr,
  input  logic [`SIGGEN_DATA_W-1:0] i_set_data,
  output siggen_pkg::siggen_cfg_t   o_cfg
);

  siggen_pkg::siggen_cfg_t cfg_q;

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      cfg_q.freq_step <= '0;
      cfg_q.start_i   <= '0;
      cfg_q.start_q   <= '0;
      // Full scale, Q1.15
      cfg_q.amplitude <= 16'h8000;
      cfg_q.pkt_size  <= 16'd64;
      cfg_q.enable    <= 1'b0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        `SIGGEN_SR_FREQ: cfg_q.freq_step <= i_set_data[`SIGGEN_PHASE_W-1:0];
        `SIGGEN_SR_CARTESIAN: begin
          cfg_q.start_i <= i_set_data[31:16];
          cfg_q.start_q <= i_set_data[15:0];
        end
        `SIGGEN_SR_ENABLE: cfg_q.enable <= i_set_data[0];
        `SIGGEN_SR_AMPLITUDE: cfg_q.amplitude <= i_set_data[15:0];
        `SIGGEN_SR_PKT_SIZE: cfg_q.pkt_size <= i_set_data[15:0];
        default: ;
      endcase
    end
  end

  assign o_cfg = cfg_q;

  // Framer relies on a nonzero size for its wrap compare
  a_pkt_size_nonzero: assert property (
    @(posedge ce_clk) disable iff (i_rst) i_set_stb |=> (o_cfg.pkt_size != 16'd0));

endmodule

// File: hw/siggen_top.sv
/*
 * Signal generator top: settings decode, tone generation, packet framing
 */
`timescale 1ns/10ps
`include "siggen_defines.svh"

module siggen_top (
  input  logic                      ce_clk,
  input  logic                      i_rst,
  input  logic                      i_set_stb,
  input  logic [`SIGGEN_ADDR_W-1:0] i_set_addr,
  input  logic [`SIGGEN_DATA_W-1:0] i_set_data,
  input  logic [15:0]               i_src_sid,
  input  logic [15:0]               i_dst_sid,
  output logic [31:0]               o_tdata,
  output logic                      o_tvalid,
  output logic                      o_tlast,
  input  logic                      i_tready,
  output siggen_pkg::cvita_hdr_t    o_hdr
);

  siggen_pkg::siggen_cfg_t    cfg;
  siggen_pkg::siggen_sample_t tone_sample;
  logic                       tone_valid;
  logic                       tone_ready;

  siggen_settings_decode u_decode (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_cfg(cfg)
  );

  tone_gen u_tone (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_cfg(cfg),
    .o_sample(tone_sample), .o_valid(tone_valid), .i_ready(tone_ready)
  );

  siggen_packet_framer u_framer (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_cfg(cfg),
    .i_src_sid(i_src_sid), .i_dst_sid(i_dst_sid),
    .i_sample(tone_sample), .i_valid(tone_valid), .o_ready(tone_ready),
    .o_tdata(o_tdata), .o_tvalid(o_tvalid), .o_tlast(o_tlast),
    .i_tready(i_tready), .o_hdr(o_hdr)
  );

endmodule

// File: hw/tone/tone_cordic.sv
/*
 * Pipelined rotation-mode CORDIC with quadrant pre-rotation and stall
 */
`timescale 1ns/10ps
`include "siggen_defines.svh"

module tone_cordic (
  input  logic                       ce_clk,
  input  logic                       i_rst,
  input  logic                       i_stall,
  input  logic                       i_valid,
  input  siggen_pkg::siggen_sample_t i_vec,
  input  logic [`SIGGEN_PHASE_W-1:0] i_phase,
  output logic                       o_valid,
  output siggen_pkg::siggen_sample_t o_vec
);

  localparam int SW = `SIGGEN_SAMPLE_W;
  localparam int PW = `SIGGEN_PHASE_W;
  localparam int NS = `SIGGEN_CORDIC_STAGES;
  // Two guard bits above the sample for gain and pre-rotation growth
  localparam int XW = SW + 2;

  // atan(2^-k) in units of 2*pi / 2^24
  localparam logic signed [PW-1:0] ATAN [NS] = '{
    24'sd2097152, 24'sd1238021, 24'sd654136, 24'sd332050, 24'sd166669,
    24'sd83416, 24'sd41718, 24'sd20860, 24'sd10430, 24'sd5215,
    24'sd2608, 24'sd1304, 24'sd652, 24'sd326
  };

  logic signed [XW-1:0] vi, vq;
  logic signed [XW-1:0] x_pre, y_pre;
  logic signed [PW-1:0] z_pre;
  logic signed [XW-1:0] x_q [NS];
  logic signed [XW-1:0] y_q [NS];
  logic signed [PW-1:0] z_q [NS];
  logic [NS-1:0]        valid_q;

  assign vi = {{(XW-SW){i_vec.i[SW-1]}}, i_vec.i};
  assign vq = {{(XW-SW){i_vec.q[SW-1]}}, i_vec.q};

  ////////////////////////////////////////////////////////////////////////////
  // Quadrant pre-rotation, residual left in [0, pi/2)
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (i_phase[PW-1 -: 2])
      2'b00: begin x_pre = vi;  y_pre = vq;  end
      2'b01: begin x_pre = -vq; y_pre = vi;  end
      2'b10: begin x_pre = -vi; y_pre = -vq; end
      default: begin x_pre = vq; y_pre = -vi; end
    endcase
    z_pre = {2'b00, i_phase[PW-3:0]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Micro-rotation stages
  ////////////////////////////////////////////////////////////////////////////
  for (genvar s = 0; s < NS; s++) begin : g_stage
    logic signed [XW-1:0] x_in, y_in;
    logic signed [PW-1:0] z_in;
    if (s == 0) begin : g_in
      assign x_in = x_pre;
      assign y_in = y_pre;
      assign z_in = z_pre;
    end else begin : g_in
      assign x_in = x_q[s-1];
      assign y_in = y_q[s-1];
      assign z_in = z_q[s-1];
    end
    always_ff @(posedge ce_clk) begin
      if (!i_stall) begin
        // Negative residual rotates back clockwise
        if (z_in[PW-1]) begin
          x_q[s] <= x_in + (y_in >>> s);
          y_q[s] <= y_in - (x_in >>> s);
          z_q[s] <= z_in + ATAN[s];
        end else begin
          x_q[s] <= x_in - (y_in >>> s);
          y_q[s] <= y_in + (x_in >>> s);
          z_q[s] <= z_in - ATAN[s];
        end
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      valid_q <= '0;
    end else if (!i_stall) begin
      valid_q <= {valid_q[NS-2:0], i_valid};
    end
  end

  assign o_valid = valid_q[NS-1];
  assign o_vec   = {x_q[NS-1][SW-1:0], y_q[NS-1][SW-1:0]};

endmodule

// File: hw/tone/tone_gen.sv
/*
 * Tone generator: phase accumulator, CORDIC rotation, amplitude scaling
 */
`timescale 1ns/10ps
`include "siggen_defines.svh"

module tone_gen (
  input  logic                       ce_clk,
  input  logic                       i_rst,
  input  siggen_pkg::siggen_cfg_t    i_cfg,
  output siggen_pkg::siggen_sample_t o_sample,
  output logic                       o_valid,
  input  logic                       i_ready
);

  logic                       stall;
  logic                       acc_valid_q;
  logic [`SIGGEN_PHASE_W-1:0] phase_q;
  siggen_pkg::siggen_sample_t start_vec;
  siggen_pkg::siggen_sample_t cordic_vec;
  logic                       cordic_valid;
  logic signed [16:0]         amp_s;
  logic signed [32:0]         prod_i, prod_q;
  siggen_pkg::siggen_sample_t sample_q;
  logic                       out_valid_q;

  // Output held and not taken freezes every stage
  assign stall = out_valid_q && !i_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Phase accumulator
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      acc_valid_q <= 1'b0;
      phase_q     <= '0;
    end else if (!stall) begin
      acc_valid_q <= i_cfg.enable;
      // Step once the held phase has moved into the CORDIC
      if (acc_valid_q) begin
        phase_q <= phase_q + i_cfg.freq_step;
      end
    end
  end

  assign start_vec = {i_cfg.start_i, i_cfg.start_q};

  tone_cordic u_cordic (
    .ce_clk  (ce_clk),
    .i_rst   (i_rst),
    .i_stall (stall),
    .i_valid (acc_valid_q),
    .i_vec   (start_vec),
    .i_phase (phase_q),
    .o_valid (cordic_valid),
    .o_vec   (cordic_vec)
  );

  // Unsigned Q1.15 scale, truncated back to the sample width
  assign amp_s  = $signed({1'b0, i_cfg.amplitude});
  assign prod_i = $signed(cordic_vec.i) * amp_s;
  assign prod_q = $signed(cordic_vec.q) * amp_s;

  always_ff @(posedge ce_clk) begin
    if (!stall) begin
      sample_q <= {prod_i[30:15], prod_q[30:15]};
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      out_valid_q <= 1'b0;
    end else if (!stall) begin
      out_valid_q <= cordic_valid;
    end
  end

  assign o_sample = sample_q;
  assign o_valid  = out_valid_q;

  // Stall holds the output and the CORDIC stage behind it
  a_hold_on_stall: assert property (
    @(posedge ce_clk) disable iff (i_rst) (o_valid && !i_ready) |=>
      ($stable(o_sample) && $stable(cordic_vec) && $stable(cordic_valid)));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the signal generator testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  -f siggen.f \
  --top-module siggen_tb \
  -Mdir build/obj

./build/obj/Vsiggen_tb | tee build/sim.log

# The testbench prints the pass message only when every check held
grep -q "Simulation completed successfully" build/sim.log

// File: siggen.f
+incdir+common
common/siggen_pkg.sv
hw/siggen_settings_decode.sv
hw/tone/tone_cordic.sv
hw/tone/tone_gen.sv
hw/siggen_packet_framer.sv
hw/siggen_top.sv
verif/siggen_checker.sv
verif/siggen_tb.sv

// File: verif/siggen_cases.txt
# c: freq_step(hex) start_i start_q amplitude(hex) pkt_size count random_ready n_expected
# e: expected i q of one transfer, the list repeats with period n_expected
c 000000 1000 0 8000 8 40 0 1
e 1647 0
c 400000 1000 0 8000 5 40 0 4
e 1647 0
e 0 1649
e -1648 1
e -1 -1648
c 400000 1000 0 8000 6 40 1 4
e 1647 0
e 0 1649
e -1648 1
e -1 -1648
c 000000 1000 0 4000 3 21 1 1
e 823 0
c 400000 1000 0 4000 7 30 1 4
e 823 0
e 0 824
e -824 0
e -1 -824

// File: verif/siggen_checker.sv
/*
 * Stream monitor: sample, last, header and stall checks, per-case report
 */
`timescale 1ns/10ps

module siggen_checker (
  input  logic                   ce_clk,
  input  logic                   i_rst,
  input  logic [31:0]            i_tdata,
  input  logic                   i_tvalid,
  input  logic                   i_tlast,
  input  logic                   i_tready,
  input  siggen_pkg::cvita_hdr_t i_hdr,
  input  logic [15:0]            i_src_sid,
  input  logic [15:0]            i_dst_sid,
  input  logic                   i_active,
  input  logic                   i_idle,
  input  logic                   i_drain,
  input  logic                   i_case_done,
  input  int                     i_case_num,
  input  logic [15:0]            i_pkt_size,
  input  int                     i_exp_len,
  input  logic [31:0]            i_exp [8],
  output int                     o_xfers,
  output int                     o_total_xfers,
  output int                     o_errors
);

  int          case_errors;
  int          drain_xfers;
  logic        prev_stall;
  logic [31:0] prev_data;

  initial begin
    o_xfers       = 0;
    o_total_xfers = 0;
    o_errors      = 0;
    case_errors   = 0;
    drain_xfers   = 0;
    prev_stall    = 1'b0;
    prev_data     = '0;
  end

  task automatic report(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    case_errors++;
    o_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks on every rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge ce_clk) begin : p_check
    logic [31:0] exp_word;
    logic        exp_last;
    logic [11:0] exp_seq;
    if (i_rst) begin
      o_xfers     = 0;
      case_errors = 0;
      drain_xfers = 0;
      prev_stall  = 1'b0;
    end else begin
      if (i_tlast && !i_tvalid) report("tlast high without tvalid");
      if (i_idle && i_tvalid) report("tvalid high while the generator is disabled");
      // Stalled beat must stay put
      if (prev_stall && (!i_tvalid || i_tdata !== prev_data)) begin
        report($sformatf("stalled beat changed from %h to %h", prev_data, i_tdata));
      end
      if (i_tvalid && i_tready && i_active) begin
        exp_word = i_exp[o_xfers % i_exp_len];
        exp_last = ((o_xfers + 1) % i_pkt_size) == 0;
        exp_seq  = 12'((o_xfers / i_pkt_size) % 4096);
        if (i_tdata !== exp_word) begin
          report($sformatf("sample %0d got %h, expected %h", o_xfers, i_tdata, exp_word));
        end
        if (i_tlast !== exp_last) begin
          report($sformatf("sample %0d tlast %b, expected %b", o_xfers, i_tlast, exp_last));
        end
        if (i_hdr.seqnum !== exp_seq) begin
          report($sformatf("seqnum %0d, expected %0d", i_hdr.seqnum, exp_seq));
        end
        if (i_hdr.length !== 16'(4 * i_pkt_size)) begin
          report($sformatf("header length %0d, expected %0d", i_hdr.length, 4 * i_pkt_size));
        end
        if (i_hdr.src_sid !== i_src_sid || i_hdr.dst_sid !== i_dst_sid) begin
          report($sformatf("header sids %h/%h", i_hdr.src_sid, i_hdr.dst_sid));
        end
        if (i_hdr.pkt_type !== 2'b00 || i_hdr.eob !== 1'b0 || i_hdr.has_time !== 1'b0) begin
          report("header type, eob or has_time not zero");
        end
        o_xfers++;
        o_total_xfers++;
        if (i_drain) begin
          drain_xfers++;
          if (drain_xfers == 17) report("more than 16 samples after enable was cleared");
        end
      end
      prev_stall = i_tvalid && !i_tready;
      prev_data  = i_tdata;
      if (i_case_done) begin
        $display("case %0d: %0d samples, %0d errors", i_case_num, o_xfers, case_errors);
      end
    end
  end

endmodule

// File: verif/siggen_tb.sv
/*
 * Signal generator testbench: clock, reset, cases file, stimulus, watchdog
 */
`timescale 1ns/10ps
`include "siggen_defines.svh"

module siggen_tb;

  localparam int MAX_CASES = 8;
  localparam int MAX_EXP   = 8;

  logic        ce_clk   = 1'b0;
  logic        i_rst    = 1'b1;
  logic        set_stb  = 1'b0;
  logic [7:0]  set_addr = '0;
  logic [31:0] set_data = '0;
  logic [15:0] src_sid  = 16'h0a11;
  logic [15:0] dst_sid  = 16'h0b22;
  logic        tready   = 1'b1;
  logic [31:0] tdata;
  logic        tvalid;
  logic        tlast;
  siggen_pkg::cvita_hdr_t hdr;

  // Checker control
  logic        active    = 1'b0;
  logic        idle      = 1'b0;
  logic        drain     = 1'b0;
  logic        case_done = 1'b0;
  int          case_num  = 0;
  logic [15:0] pkt_size  = 16'd1;
  int          exp_len   = 1;
  logic [31:0] exp_cur [MAX_EXP];
  int          xfers;
  int          total_xfers;
  int          errors;

  // Cases file contents
  int          num_cases = 0;
  int          c_freq [MAX_CASES];
  int          c_si [MAX_CASES];
  int          c_sq [MAX_CASES];
  int          c_amp [MAX_CASES];
  int          c_pkt [MAX_CASES];
  int          c_count [MAX_CASES];
  int          c_rand [MAX_CASES];
  int          c_nexp [MAX_CASES];
  int          c_got [MAX_CASES];
  logic [31:0] c_exp [MAX_CASES][MAX_EXP];
  int          limit_cycles = 0;
  logic        rand_mode = 1'b0;
  logic [31:0] lfsr = 32'h1d5b_c5c1;
  bit          load_ok;

  siggen_top uut (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_src_sid(src_sid), .i_dst_sid(dst_sid),
    .o_tdata(tdata), .o_tvalid(tvalid), .o_tlast(tlast),
    .i_tready(tready), .o_hdr(hdr)
  );

  siggen_checker u_check (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_tdata(tdata), .i_tvalid(tvalid), .i_tlast(tlast), .i_tready(tready), .i_hdr(hdr),
    .i_src_sid(src_sid), .i_dst_sid(dst_sid),
    .i_active(active), .i_idle(idle), .i_drain(drain), .i_case_done(case_done),
    .i_case_num(case_num), .i_pkt_size(pkt_size), .i_exp_len(exp_len), .i_exp(exp_cur),
    .o_xfers(xfers), .o_total_xfers(total_xfers), .o_errors(errors)
  );

  initial begin
    forever #20 ce_clk = ~ce_clk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  always @(negedge ce_clk) begin
    if (rand_mode) begin
      lfsr   = lfsr_next(lfsr);
      tready = lfsr[0];
    end else begin
      tready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cases file reader
  ////////////////////////////////////////////////////////////////////////////
  task automatic load_cases(output bit ok);
    int    fd;
    int    n;
    int    f, si, sq, amp, pkt, cnt, rnd, ne, ei, eq;
    string line;
    ok = 1'b0;
    fd = $fopen("verif/siggen_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line.getc(0) == "c" && num_cases < MAX_CASES) begin
          n = $sscanf(line, "c %h %d %d %h %d %d %d %d", f, si, sq, amp, pkt, cnt, rnd, ne);
          if (n == 8) begin
            c_freq[num_cases]  = f;
            c_si[num_cases]    = si;
            c_sq[num_cases]    = sq;
            c_amp[num_cases]   = amp;
            c_pkt[num_cases]   = pkt;
            c_count[num_cases] = cnt;
            c_rand[num_cases]  = rnd;
            c_nexp[num_cases]  = ne;
            c_got[num_cases]   = 0;
            num_cases++;
          end
        end else if (line.len() > 0 && line.getc(0) == "e" && num_cases > 0) begin
          n = $sscanf(line, "e %d %d", ei, eq);
          if (n == 2 && c_got[num_cases-1] < MAX_EXP) begin
            c_exp[num_cases-1][c_got[num_cases-1]] = {ei[15:0], eq[15:0]};
            c_got[num_cases-1]++;
          end
        end
      end
      $fclose(fd);
      ok = (num_cases > 0);
      for (int c = 0; c < num_cases; c++) begin
        if (c_got[c] != c_nexp[c] || c_nexp[c] == 0) ok = 1'b0;
        limit_cycles += 4 * c_count[c] + 200;
      end
    end
  endtask

  // Called right after a falling edge
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge ce_clk);
    set_stb  = 1'b0;
  endtask

  task automatic apply_reset();
    i_rst = 1'b1;
    repeat (5) @(negedge ce_clk);
    i_rst = 1'b0;
  endtask

  task automatic run_case(input int c);
    int quiet;
    case_num = c;
    pkt_size = c_pkt[c][15:0];
    exp_len  = c_nexp[c];
    for (int k = 0; k < MAX_EXP; k++) exp_cur[k] = c_exp[c][k];
    apply_reset();
    rand_mode = c_rand[c][0];
    idle = 1'b1;
    // Unused addresses must leave the generator silent
    write_reg(8'h10, 32'hffff_ffff);
    write_reg(8'd129, 32'h1);
    write_reg(8'd133, 32'h1);
    write_reg(`SIGGEN_SR_FREQ, c_freq[c]);
    write_reg(`SIGGEN_SR_CARTESIAN, {c_si[c][15:0], c_sq[c][15:0]});
    write_reg(`SIGGEN_SR_AMPLITUDE, c_amp[c]);
    write_reg(`SIGGEN_SR_PKT_SIZE, c_pkt[c]);
    repeat (20) @(negedge ce_clk);
    idle   = 1'b0;
    active = 1'b1;
    write_reg(`SIGGEN_SR_ENABLE, 32'h1);
    wait (xfers >= c_count[c]);
    @(negedge ce_clk);
    write_reg(`SIGGEN_SR_ENABLE, 32'h0);
    drain = 1'b1;
    // Drain until the stream has been quiet for a while
    quiet = 0;
    while (quiet < 20) begin
      @(negedge ce_clk);
      quiet = tvalid ? 0 : quiet + 1;
    end
    case_done = 1'b1;
    @(negedge ce_clk);
    case_done = 1'b0;
    drain     = 1'b0;
    active    = 1'b0;
  endtask

  initial begin
    for (int k = 0; k < MAX_EXP; k++) exp_cur[k] = '0;
    load_cases(load_ok);
    if (!load_ok) begin
      $display("Could not read a valid case list from verif/siggen_cases.txt");
      $display("Simulation failed");
    end else begin
      @(negedge ce_clk);
      for (int c = 0; c < num_cases; c++) run_case(c);
      $display("cases: %0d, samples checked: %0d, errors: %0d", num_cases, total_xfers, errors);
      if (errors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
    end
    $finish;
  end

  // Watchdog sized from the case lengths
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge ce_clk);
    $display("Watchdog expired after %0d cycles, the stream did not finish", limit_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule
